/* build.f */
+incdir+rtl
rtl/wx_pkg.sv
rtl/wx_sel_fifo.sv
rtl/wx_wdata_mux.sv
rtl/wx_aw_arbiter.sv
rtl/wx_write_xbar.sv
sim/wx_properties.sv
sim/wx_tb.sv

/* sim/wx_tb.sv */
`timescale 1ns/1ps
`include "wx_params.svh"

module wx_tb;
  import wx_pkg::*;

  localparam int N = `WX_NUM_SRC;
  localparam int BURSTS = 12;
  localparam int MAX_BEATS = 4;
  localparam int SEL_DEPTH = 1 << `WX_SEL_DEPTH_LOG;
  localparam int LIMIT = N * BURSTS * MAX_BEATS * 8 + 200;
  localparam int STALL_START = 40;
  localparam int STALL_LEN = 120;

  logic aclk;
  logic rst_n;
  src_vec_t s_aw_valid;
  src_vec_t s_aw_ready;
  aw_req_t s_aw [N];
  src_vec_t s_w_valid;
  src_vec_t s_w_ready;
  w_beat_t s_w [N];
  logic m_aw_valid;
  logic m_aw_ready;
  aw_req_t m_aw;
  logic m_w_valid;
  logic m_w_ready;
  w_beat_t m_w;

  addr_t b_addr [N][BURSTS];
  len_t b_len [N][BURSTS];
  w_beat_t b_beat [N][BURSTS][MAX_BEATS];

  int aw_sent [N];      // Bursts of each source whose AW was granted
  int w_burst [N];
  int w_beat [N];
  src_vec_t aw_took;
  src_vec_t w_took;

  w_beat_t exp_w [$];
  int exp_src [$];
  int exp_cyc [$];      // Cycle of the AW grant that queued the beat

  logic [31:0] rng;
  int errors;
  int prop_fails;
  int cycle;
  int rr_ptr;
  bit aw_held;
  int aw_win;
  int granted;
  int completed;

  wx_write_xbar dut0 (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .s_aw_valid(s_aw_valid),
    .s_aw_ready(s_aw_ready),
    .s_aw      (s_aw),
    .s_w_valid (s_w_valid),
    .s_w_ready (s_w_ready),
    .s_w       (s_w),
    .m_aw_valid(m_aw_valid),
    .m_aw_ready(m_aw_ready),
    .m_aw      (m_aw),
    .m_w_valid (m_w_valid),
    .m_w_ready (m_w_ready),
    .m_w       (m_w)
  );

  initial aclk = 1'b0;
  always #50 aclk = ~aclk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift(rng);
    return rng;
  endfunction

  // First requesting source at or after ptr
  function automatic int rr_pick(input int ptr, input src_vec_t req);
    int idx;
    for (int k = 0; k < N; k++) begin
      idx = (ptr + k) % N;
      if (req[idx]) begin
        return idx;
      end
    end
    return 0;
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp,
                             input logic [63:0] act);
    if (exp !== act) begin
      errors++;
      $display("Error %s: expected %h, actual %h (cycle %0d)", name, exp, act, cycle);
    end
  endtask

  task automatic build_bursts();
    logic [31:0] r;
    for (int i = 0; i < N; i++) begin
      for (int b = 0; b < BURSTS; b++) begin
        b_addr[i][b] = next_rand();
        r = next_rand();
        b_len[i][b] = len_t'(r[1:0]);    // One to four beats
        for (int k = 0; k < MAX_BEATS; k++) begin
          b_beat[i][b][k].data = next_rand();
          r = next_rand();
          b_beat[i][b][k].strb = r[3:0];
          b_beat[i][b][k].last = (k == int'(b_len[i][b]));
        end
      end
    end
  endtask

  task automatic drive_inputs();
    logic [31:0] r;
    for (int i = 0; i < N; i++) begin
      if (aw_took[i]) begin
        s_aw_valid[i] = 1'b0;
        aw_sent[i]++;
      end
      if (w_took[i]) begin
        s_w_valid[i] = 1'b0;
        if (s_w[i].last) begin
          w_burst[i]++;
          w_beat[i] = 0;
        end else begin
          w_beat[i]++;
        end
      end
      r = next_rand();
      if (!s_aw_valid[i] && aw_sent[i] < BURSTS && r[0]) begin
        s_aw_valid[i] = 1'b1;
        s_aw[i].addr = b_addr[i][aw_sent[i]];
        s_aw[i].len = b_len[i][aw_sent[i]];
        s_aw[i].src = src_idx_t'(r[9:8]);    // Junk ID that the arbiter replaces
      end
      if (!s_w_valid[i] && w_burst[i] < BURSTS && r[3:2] != 2'b00) begin
        s_w_valid[i] = 1'b1;
        s_w[i] = b_beat[i][w_burst[i]][w_beat[i]];
      end
    end
    r = next_rand();
    m_aw_ready = (r[1:0] != 2'b00);
    if (cycle >= STALL_START && cycle < STALL_START + STALL_LEN) begin
      m_w_ready = 1'b0;    // Long W stall that fills the select FIFO
    end else begin
      m_w_ready = (r[5:4] != 2'b00);
    end
  endtask

  // Sampled mid-cycle, the values seen here are the ones the next edge sees
  task automatic observe_outputs();
    logic pop;
    logic grant;
    logic head_ok;
    logic exp_valid;
    int outstanding;
    int s;
    w_beat_t beat;
    pop = 1'b0;
    outstanding = granted - completed;
    // A granted burst reaches the FIFO head one cycle after its grant
    head_ok = (exp_w.size() != 0) && (cycle > exp_cyc[0]);
    s = head_ok ? exp_src[0] : 0;
    exp_valid = head_ok && s_w_valid[s];
    check_value("w_valid", exp_valid, m_w_valid);
    check_value("w_ready", (head_ok && m_w_ready) ? (1 << s) : 0, s_w_ready);
    if (exp_valid && m_w_ready) begin
      beat = exp_w.pop_front();
      void'(exp_src.pop_front());
      void'(exp_cyc.pop_front());
      check_value("w_beat", beat, m_w);
      pop = beat.last;
      if (pop) begin
        completed++;
      end
    end
    if (!aw_held && s_aw_valid != '0) begin
      aw_win = rr_pick(rr_ptr, s_aw_valid);
      aw_held = 1'b1;
    end
    check_value("aw_valid", aw_held, m_aw_valid);
    grant = aw_held && m_aw_ready && (outstanding < SEL_DEPTH || pop);
    check_value("aw_ready", grant ? (1 << aw_win) : 0, s_aw_ready);
    if (aw_held) begin
      check_value("aw_src", aw_win, m_aw.src);
      check_value("aw_addr", b_addr[aw_win][aw_sent[aw_win]], m_aw.addr);
      check_value("aw_len", b_len[aw_win][aw_sent[aw_win]], m_aw.len);
    end
    if (grant) begin
      for (int k = 0; k <= int'(b_len[aw_win][aw_sent[aw_win]]); k++) begin
        exp_w.push_back(b_beat[aw_win][aw_sent[aw_win]][k]);
        exp_src.push_back(aw_win);
        exp_cyc.push_back(cycle);
      end
      granted++;
      rr_ptr = (aw_win + 1) % N;
      aw_held = 1'b0;
    end
    // The long W stall must have driven the select FIFO to full
    if (cycle == STALL_START + STALL_LEN - 1) begin
      check_value("sel_fifo_filled", SEL_DEPTH, granted - completed);
    end
    aw_took = s_aw_valid & s_aw_ready;
    w_took = s_w_valid & s_w_ready;
  endtask

  initial begin
    rst_n = 1'b0;
    s_aw_valid = '0;
    s_w_valid = '0;
    m_aw_ready = 1'b0;
    m_w_ready = 1'b0;
    for (int i = 0; i < N; i++) begin
      s_aw[i] = '0;
      s_w[i] = '0;
      aw_sent[i] = 0;
      w_burst[i] = 0;
      w_beat[i] = 0;
    end
    aw_took = '0;
    w_took = '0;
    errors = 0;
    prop_fails = 0;
    cycle = 0;
    rr_ptr = 0;
    aw_held = 1'b0;
    aw_win = 0;
    granted = 0;
    completed = 0;
    rng = 32'hf2a5d01f;
    build_bursts();

    repeat (10) @(posedge aclk);
    #1 rst_n = 1'b1;
    repeat (5) begin
      @(negedge aclk);
      check_value("idle_quiet", 0, {m_aw_valid, m_w_valid, s_aw_ready, s_w_ready});
    end

    while (completed < N * BURSTS && cycle < LIMIT) begin
      @(posedge aclk);
      #1;
      drive_inputs();
      @(negedge aclk);
      observe_outputs();
      cycle++;
    end

    if (completed < N * BURSTS) begin
      errors++;
      $display("Timeout: only %0d of %0d bursts completed after %0d cycles",
               completed, N * BURSTS, cycle);
    end
    check_value("leftover_beats", 0, exp_w.size());
    prop_fails = dut0.u_props.fail_count;
    $display("Check summary: %0d model errors, %0d assertion failures", errors, prop_fails);
    if (errors == 0 && prop_fails == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* sim/wx_properties.sv */
`timescale 1ns/1ps

module wx_properties (
  input logic             aclk,
  input logic             rst_n,
  input wx_pkg::src_vec_t s_aw_ready,
  input wx_pkg::src_vec_t s_w_ready,
  input logic             m_aw_valid,
  input wx_pkg::aw_req_t  m_aw,
  input logic             m_w_valid,
  input logic             m_w_ready,
  input wx_pkg::w_beat_t  m_w
);

  int fail_count = 0;    // Read by the testbench at the end of the run

  // An address offered downstream but not granted keeps its payload
  aw_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_aw_valid && (s_aw_ready == '0) |=> m_aw_valid && $stable(m_aw))
    else begin
      fail_count++;
      $error("m_aw dropped or changed while its grant was stalled");
    end

  w_stall_stable: assert property (@(posedge aclk) disable iff (!rst_n)
    m_w_valid && !m_w_ready |=> m_w_valid && $stable(m_w))
    else begin
      fail_count++;
      $error("m_w dropped or changed while the target held it off");
    end

  reset_quiet: assert property (@(posedge aclk)
    $rose(rst_n) |-> !m_aw_valid && !m_w_valid && (s_aw_ready == '0) && (s_w_ready == '0))
    else begin
      fail_count++;
      $error("valid or ready output high in the first cycle after reset");
    end

  w_ready_onehot: assert property (@(posedge aclk) disable iff (!rst_n)
    $onehot0(s_w_ready))
    else begin
      fail_count++;
      $error("more than one source sees s_w_ready");
    end

endmodule

bind wx_write_xbar wx_properties u_props (
  .aclk      (aclk),
  .rst_n     (rst_n),
  .s_aw_ready(s_aw_ready),
  .s_w_ready (s_w_ready),
  .m_aw_valid(m_aw_valid),
  .m_aw      (m_aw),
  .m_w_valid (m_w_valid),
  .m_w_ready (m_w_ready),
  .m_w       (m_w)
);

/* rtl/wx_write_xbar.sv */
`timescale 1ns/1ps
`include "wx_params.svh"

module wx_write_xbar (
  input  logic             aclk,
  input  logic             rst_n,
  input  wx_pkg::src_vec_t s_aw_valid,
  output wx_pkg::src_vec_t s_aw_ready,
  input  wx_pkg::aw_req_t  s_aw [`WX_NUM_SRC],
  input  wx_pkg::src_vec_t s_w_valid,
  output wx_pkg::src_vec_t s_w_ready,
  input  wx_pkg::w_beat_t  s_w [`WX_NUM_SRC],
  output logic             m_aw_valid,
  input  logic             m_aw_ready,
  output wx_pkg::aw_req_t  m_aw,
  output logic             m_w_valid,
  input  logic             m_w_ready,
  output wx_pkg::w_beat_t  m_w
);
  import wx_pkg::*;

  // Ordering link from the address grant to the data steering
  logic sel_push_valid;
  logic sel_push_ready;
  src_idx_t sel_push_idx;

  wx_aw_arbiter u_arb (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .s_aw_valid    (s_aw_valid),
    .s_aw_ready    (s_aw_ready),
    .s_aw          (s_aw),
    .m_aw_valid    (m_aw_valid),
    .m_aw_ready    (m_aw_ready),
    .m_aw          (m_aw),
    .sel_push_valid(sel_push_valid),
    .sel_push_ready(sel_push_ready),
    .sel_push_idx  (sel_push_idx)
  );

  wx_wdata_mux u_wmux (
    .aclk          (aclk),
    .rst_n         (rst_n),
    .sel_push_valid(sel_push_valid),
    .sel_push_ready(sel_push_ready),
    .sel_push_idx  (sel_push_idx),
    .s_w_valid     (s_w_valid),
    .s_w_ready     (s_w_ready),
    .s_w           (s_w),
    .m_w_valid     (m_w_valid),
    .m_w_ready     (m_w_ready),
    .m_w           (m_w)
  );

endmodule

/* rtl/wx_aw_arbiter.sv */
`timescale 1ns/1ps
`include "wx_params.svh"

module wx_aw_arbiter (
  input  logic             aclk,
  input  logic             rst_n,
  input  wx_pkg::src_vec_t s_aw_valid,
  output wx_pkg::src_vec_t s_aw_ready,
  input  wx_pkg::aw_req_t  s_aw [`WX_NUM_SRC],
  output logic             m_aw_valid,
  input  logic             m_aw_ready,
  output wx_pkg::aw_req_t  m_aw,
  output logic             sel_push_valid,
  input  logic             sel_push_ready,
  output wx_pkg::src_idx_t sel_push_idx
);
  import wx_pkg::*;

  localparam int N = `WX_NUM_SRC;

  src_idx_t rr_ptr;      // Highest priority source for the next search
  logic hold_q;          // Grant offered downstream and not yet taken
  src_idx_t hold_idx_q;
  src_idx_t found_idx;
  src_idx_t win_idx;
  src_idx_t next_ptr;
  logic grant_done;

  // Walk backwards so the first valid source after rr_ptr wins
  always_comb begin
    int unsigned cand;
    found_idx = rr_ptr;
    for (int k = N - 1; k >= 0; k--) begin
      cand = (int'(rr_ptr) + k) % N;
      if (s_aw_valid[cand]) begin
        found_idx = src_idx_t'(cand);
      end
    end
  end

  assign win_idx = hold_q ? hold_idx_q : found_idx;

  // Valid only depends on upstream valids, never on downstream ready
  assign m_aw_valid = s_aw_valid[win_idx];
  assign sel_push_valid = m_aw_valid & m_aw_ready;    // Index is queued only as the target takes the address
  assign sel_push_idx = win_idx;

  // Both the target and the select FIFO must accept in the same cycle
  assign grant_done = m_aw_valid & m_aw_ready & sel_push_ready;

  always_comb begin
    m_aw = s_aw[win_idx];
    m_aw.src = win_idx;    // Port position replaces whatever the source sent
  end

  always_comb begin
    s_aw_ready = '0;
    if (grant_done) begin
      s_aw_ready[win_idx] = 1'b1;
    end
  end

  assign next_ptr = (win_idx == src_idx_t'(N - 1)) ? '0 : win_idx + 1'b1;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      rr_ptr <= '0;
      hold_q <= 1'b0;
    end else if (grant_done) begin
      rr_ptr <= next_ptr;
      hold_q <= 1'b0;
    end else if (m_aw_valid) begin
      hold_q <= 1'b1;
    end
  end

  // Winner is captured while the grant stalls, so a later request from a
  // higher priority source cannot swap the offered address
  always_ff @(posedge aclk) begin
    if (m_aw_valid && !grant_done) begin
      hold_idx_q <= win_idx;
    end
  end

endmodule

/* rtl/wx_wdata_mux.sv */
`timescale 1ns/1ps
`include "wx_params.svh"

module wx_wdata_mux (
  input  logic             aclk,
  input  logic             rst_n,
  input  logic             sel_push_valid,
  output logic             sel_push_ready,
  input  wx_pkg::src_idx_t sel_push_idx,
  input  wx_pkg::src_vec_t s_w_valid,
  output wx_pkg::src_vec_t s_w_ready,
  input  wx_pkg::w_beat_t  s_w [`WX_NUM_SRC],
  output logic             m_w_valid,
  input  logic             m_w_ready,
  output wx_pkg::w_beat_t  m_w
);
  import wx_pkg::*;

  logic head_valid;
  logic head_ready;
  src_idx_t head_idx;
  src_vec_t head_hot;

  wx_sel_fifo #(
    .DEPTH_LOG(`WX_SEL_DEPTH_LOG)
  ) u_sel_fifo (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .push_valid(sel_push_valid),
    .push_ready(sel_push_ready),
    .push_idx  (sel_push_idx),
    .head_valid(head_valid),
    .head_ready(head_ready),
    .head_idx  (head_idx)
  );

  always_comb begin
    for (int i = 0; i < `WX_NUM_SRC; i++) begin
      head_hot[i] = (head_idx == i);
    end
  end

  // One-hot mux, zero when nothing is selected
  always_comb begin
    m_w = '0;
    for (int i = 0; i < `WX_NUM_SRC; i++) begin
      if (head_hot[i]) begin
        m_w = s_w[i];
      end
    end
  end

  assign m_w_valid = head_valid & |(s_w_valid & head_hot);
  assign s_w_ready = head_hot & {`WX_NUM_SRC{head_valid & m_w_ready}};

  // Last beat retires the burst so the next one in address order takes over
  assign head_ready = m_w_valid & m_w_ready & m_w.last;

endmodule

/* rtl/wx_sel_fifo.sv */
`timescale 1ns/1ps
`include "wx_params.svh"

module wx_sel_fifo #(
  parameter int DEPTH_LOG = `WX_SEL_DEPTH_LOG
) (
  input  logic             aclk,
  input  logic             rst_n,
  input  logic             push_valid,
  output logic             push_ready,
  input  wx_pkg::src_idx_t push_idx,
  output logic             head_valid,
  input  logic             head_ready,
  output wx_pkg::src_idx_t head_idx
);
  import wx_pkg::*;

  localparam int DEPTH = 1 << DEPTH_LOG;

  src_idx_t mem [DEPTH];

  logic [DEPTH_LOG-1:0] wr_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr;
  logic [DEPTH_LOG-1:0] rd_ptr_next;
  logic [DEPTH_LOG:0] count;
  logic [DEPTH_LOG:0] remain;
  logic [DEPTH_LOG:0] count_next;
  logic do_push;
  logic do_pop;

  assign do_pop = head_valid & head_ready;

  // A pop in the same cycle frees the slot the push needs
  assign push_ready = (count != DEPTH) | do_pop;
  assign do_push = push_valid & push_ready;

  always_comb begin
    if (do_pop) begin
      rd_ptr_next = rd_ptr + 1'b1;
      remain = count - 1'b1;
    end else begin
      rd_ptr_next = rd_ptr;
      remain = count;
    end
  end

  assign count_next = do_push ? remain + 1'b1 : remain;

  always_ff @(posedge aclk) begin
    if (do_push) begin
      mem[wr_ptr] <= push_idx;
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      head_valid <= 1'b0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      rd_ptr <= rd_ptr_next;
      count <= count_next;
      head_valid <= (count_next != '0);
    end
  end

  // Head register tracks the entry at the next read pointer.
  // When the FIFO drains to nothing and a push lands, the new index goes
  // straight to the head since the memory write is not visible yet
  always_ff @(posedge aclk) begin
    if (do_push && (remain == '0)) begin
      head_idx <= push_idx;
    end else begin
      head_idx <= mem[rd_ptr_next];
    end
  end

endmodule

/* rtl/wx_pkg.sv */
`include "wx_params.svh"

package wx_pkg;

  typedef logic [`WX_SRC_W-1:0] src_idx_t;
  typedef logic [`WX_NUM_SRC-1:0] src_vec_t;

  typedef logic [`WX_ADDR_W-1:0] addr_t;
  typedef logic [`WX_DATA_W-1:0] data_t;
  typedef logic [`WX_DATA_W/8-1:0] strb_t;
  typedef logic [`WX_LEN_W-1:0] len_t;    // Beats minus one

  // One write address, src doubles as the transaction ID at the target
  typedef struct packed {
    addr_t addr;
    len_t len;
    src_idx_t src;
  } aw_req_t;

  // One write data beat
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic last;
  } w_beat_t;

endpackage

/* rtl/wx_params.svh */
`ifndef WX_PARAMS_SVH
`define WX_PARAMS_SVH

// Upstream source count and index width
`define WX_NUM_SRC 4
`define WX_SRC_W 2

// Write address channel fields
`define WX_ADDR_W 32
`define WX_LEN_W 8

// Write data channel width, strobes follow as one bit per byte
`define WX_DATA_W 32

// Select FIFO holds 2**WX_SEL_DEPTH_LOG outstanding burst indices
`define WX_SEL_DEPTH_LOG 2

`endif
